// ==== Bender.yml ====
package:
  name: mips_debug

dependencies: {}

sources:
  # package and interfaces first
  - rtl/mips_debug_pkg.sv
  - rtl/uart_link_if.sv
  - rtl/uart.sv
  - rtl/debug_unit.sv
  - rtl/mips_core.sv
  - rtl/mips_debug_top.sv
  - target: simulation
    files:
      - verification/mips_debug_chk.sv
      - verification/mips_debug_tb.sv

// ==== build.f ====
rtl/mips_debug_pkg.sv
rtl/uart_link_if.sv
rtl/uart.sv
rtl/debug_unit.sv
rtl/mips_core.sv
rtl/mips_debug_top.sv
verification/mips_debug_chk.sv
verification/mips_debug_tb.sv

// ==== rtl/debug_unit.sv ====
`default_nettype none

module debug_unit (
	input logic clk,
	input logic rst,
	uart_link_if.debug link,
	core_dbg_if.debug core
);

	logic [2:0] state;
	// words still to load
	logic [7:0] words_left;
	// byte position inside the word being loaded
	logic [1:0] byte_idx;
	logic [mips_debug_pkg::imem_addr_w-1:0] wr_addr;
	logic step_mode;
	logic [5:0] dump_idx;
	// byte handed to uart, tx_done not seen yet
	logic tx_busy;
	logic [31:0] word_sr;
	logic [31:0] dump_word;
	logic [7:0] dump_byte;
	logic is_exec_cmd;

	assign is_exec_cmd = (link.rx_data == mips_debug_pkg::cmd_run) ||
		(link.rx_data == mips_debug_pkg::cmd_step);

	////////////////////////////////////////////////////////////////////////////
	// dump byte select
	////////////////////////////////////////////////////////////////////////////

	// words 0..7 are regs, word 8 is pc
	always_comb begin
		if (dump_idx[5:2] < 4'(mips_debug_pkg::num_regs))
			dump_word = core.regs[dump_idx[4:2]];
		else
			dump_word = core.pc;
		// lsb first within each word
		dump_byte = dump_word[8*dump_idx[1:0] +: 8];
	end

	////////////////////////////////////////////////////////////////////////////
	// command FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= mips_debug_pkg::dbg_idle;
			words_left <= '0;
			byte_idx <= '0;
			wr_addr <= '0;
			step_mode <= 1'b0;
			dump_idx <= '0;
			tx_busy <= 1'b0;
			link.tx_start <= 1'b0;
			core.imem_we <= 1'b0;
			core.imem_addr <= '0;
			core.run_en <= 1'b0;
			core.clear <= 1'b0;
		end else begin
			// strobes default low
			link.tx_start <= 1'b0;
			core.imem_we <= 1'b0;
			core.clear <= 1'b0;
			case (state)
				mips_debug_pkg::dbg_idle: begin
					// unknown bytes fall through
					if (link.rx_done) begin
						if (link.rx_data == mips_debug_pkg::cmd_load) begin
							state <= mips_debug_pkg::dbg_count;
						end else if (is_exec_cmd) begin
							step_mode <= (link.rx_data == mips_debug_pkg::cmd_step);
							dump_idx <= '0;
							// already halted, just report state
							if (core.halted) begin
								state <= mips_debug_pkg::dbg_dump;
							end else begin
								core.run_en <= 1'b1;
								state <= mips_debug_pkg::dbg_run;
							end
						end
					end
				end
				mips_debug_pkg::dbg_count: begin
					if (link.rx_done) begin
						words_left <= link.rx_data;
						byte_idx <= '0;
						wr_addr <= '0;
						// empty load still restarts the core
						if (link.rx_data == 8'd0) begin
							core.clear <= 1'b1;
							state <= mips_debug_pkg::dbg_idle;
						end else begin
							state <= mips_debug_pkg::dbg_word;
						end
					end
				end
				mips_debug_pkg::dbg_word: begin
					if (link.rx_done) begin
						byte_idx <= byte_idx + 1'b1;
						// fourth byte completes the word
						if (byte_idx == 2'd3) begin
							core.imem_we <= 1'b1;
							core.imem_addr <= wr_addr;
							wr_addr <= wr_addr + 1'b1;
							words_left <= words_left - 1'b1;
							if (words_left == 8'd1) begin
								core.clear <= 1'b1;
								state <= mips_debug_pkg::dbg_idle;
							end
						end
					end
				end
				mips_debug_pkg::dbg_run: begin
					// step drops run_en after one cycle
					if (step_mode || core.halted) begin
						core.run_en <= 1'b0;
						dump_idx <= '0;
						state <= mips_debug_pkg::dbg_dump;
					end
				end
				mips_debug_pkg::dbg_dump: begin
					if (!tx_busy) begin
						link.tx_start <= 1'b1;
						tx_busy <= 1'b1;
					end else if (link.tx_done) begin
						tx_busy <= 1'b0;
						if (dump_idx == 6'(mips_debug_pkg::dump_bytes - 1))
							state <= mips_debug_pkg::dbg_idle;
						else
							dump_idx <= dump_idx + 1'b1;
					end
				end
				default: state <= mips_debug_pkg::dbg_idle;
			endcase
		end
	end

	// load word assembly, lsb byte first, and dump byte capture
	always_ff @(posedge clk) begin
		if (state == mips_debug_pkg::dbg_word && link.rx_done) begin
			word_sr <= {link.rx_data, word_sr[31:8]};
			core.imem_data <= {link.rx_data, word_sr[31:8]};
		end
		if (state == mips_debug_pkg::dbg_dump && !tx_busy)
			link.tx_data <= dump_byte;
	end

endmodule

`default_nettype wire

// ==== rtl/mips_core.sv ====
`default_nettype none

module mips_core (
	input logic clk,
	input logic rst,
	core_dbg_if.core dbg
);

	mips_debug_pkg::instr_t imem [mips_debug_pkg::imem_depth];
	mips_debug_pkg::reg_file_t rf;
	logic [31:0] pc;
	logic halted;

	// decode and execute signals
	mips_debug_pkg::instr_t ins;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] imm_ext;
	logic [31:0] pc_inc;
	logic [31:0] pc_next;
	logic [31:0] wr_val;
	logic [2:0] wr_idx;
	logic wr_en;
	logic is_halt;

	assign dbg.pc = pc;
	assign dbg.halted = halted;
	assign dbg.regs = rf;

	////////////////////////////////////////////////////////////////////////////
	// instruction memory
	////////////////////////////////////////////////////////////////////////////

	// written only by the loader
	always_ff @(posedge clk) begin
		if (dbg.imem_we)
			imem[dbg.imem_addr] <= dbg.imem_data;
	end

	////////////////////////////////////////////////////////////////////////////
	// fetch, decode, execute
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// word-addressed fetch
		ins = imem[pc[mips_debug_pkg::imem_addr_w-1:0]];
		// only 8 regs, low 3 bits of each field
		rs_val = rf[ins.r.rs[2:0]];
		rt_val = rf[ins.i.rt[2:0]];
		imm_ext = {{16{ins.i.imm16[15]}}, ins.i.imm16};
		pc_inc = pc + 32'd1;

		wr_en = 1'b0;
		wr_idx = ins.r.rd[2:0];
		wr_val = rs_val + rt_val;
		pc_next = pc_inc;
		is_halt = 1'b0;

		case (ins.r.opcode)
			mips_debug_pkg::op_rtype: begin
				// other funct codes act as nop
				if (ins.r.funct == mips_debug_pkg::funct_add) begin
					wr_en = 1'b1;
				end else if (ins.r.funct == mips_debug_pkg::funct_sub) begin
					wr_en = 1'b1;
					wr_val = rs_val - rt_val;
				end
			end
			mips_debug_pkg::op_addi: begin
				wr_en = 1'b1;
				wr_idx = ins.i.rt[2:0];
				wr_val = rs_val + imm_ext;
			end
			mips_debug_pkg::op_beq: begin
				// offset in words from pc+1
				if (rs_val == rt_val)
					pc_next = pc_inc + imm_ext;
			end
			mips_debug_pkg::op_halt: begin
				// pc stays on the halt
				is_halt = 1'b1;
				pc_next = pc;
			end
			default: begin
				pc_next = pc_inc;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// architectural state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			halted <= 1'b0;
			rf <= '0;
		end else if (dbg.clear) begin
			// regs keep their values across a reload
			pc <= '0;
			halted <= 1'b0;
		end else if (dbg.run_en && !halted) begin
			pc <= pc_next;
			if (is_halt)
				halted <= 1'b1;
			// r0 is hardwired zero
			if (wr_en && wr_idx != 3'd0)
				rf[wr_idx] <= wr_val;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/mips_debug_pkg.sv ====
`default_nettype none

package mips_debug_pkg;

	////////////////////////////////////////////////////////////////////////////
	// serial timing
	////////////////////////////////////////////////////////////////////////////

	// clock cycles per serial bit
	localparam int clks_per_bit = 8;
	localparam int baud_cnt_w = $clog2(clks_per_bit);
	// last count of a full bit, and of half a bit
	localparam logic [baud_cnt_w-1:0] bit_last = baud_cnt_w'(clks_per_bit - 1);
	localparam logic [baud_cnt_w-1:0] half_last = baud_cnt_w'(clks_per_bit / 2 - 1);

	// serial FSM states, shared by receiver and transmitter
	localparam logic [1:0] ser_idle = 2'd0;
	localparam logic [1:0] ser_start = 2'd1;
	localparam logic [1:0] ser_data = 2'd2;
	localparam logic [1:0] ser_stop = 2'd3;

	// host command bytes
	localparam logic [7:0] cmd_load = 8'h01;
	localparam logic [7:0] cmd_run = 8'h02;
	localparam logic [7:0] cmd_step = 8'h03;

	// debug FSM states
	localparam logic [2:0] dbg_idle = 3'd0;
	localparam logic [2:0] dbg_count = 3'd1;
	localparam logic [2:0] dbg_word = 3'd2;
	localparam logic [2:0] dbg_run = 3'd3;
	localparam logic [2:0] dbg_dump = 3'd4;

	////////////////////////////////////////////////////////////////////////////
	// isa subset
	////////////////////////////////////////////////////////////////////////////

	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_beq = 6'h04;
	// not a real mips opcode, stops the core
	localparam logic [5:0] op_halt = 6'h3f;
	localparam logic [5:0] funct_add = 6'h20;
	localparam logic [5:0] funct_sub = 6'h22;

	localparam int imem_depth = 128;
	localparam int imem_addr_w = 7;
	localparam int num_regs = 8;
	// 8 regs + pc, 4 bytes each
	localparam int dump_bytes = 36;

	// one fetched word, seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm16;
		} i;
	} instr_t;

	typedef logic [num_regs-1:0][31:0] reg_file_t;

endpackage

`default_nettype wire

// ==== rtl/mips_debug_top.sv ====
`default_nettype none

module mips_debug_top (
	input logic clk,
	input logic rst,
	input logic rx,
	output logic tx,
	output logic [7:0] led
);

	////////////////////////////////////////////////////////////////////////////
	// internal links
	////////////////////////////////////////////////////////////////////////////

	// uart <-> debug unit bytes
	uart_link_if link ();
	// debug unit <-> core control and readback
	core_dbg_if core_dbg ();

	// serial line to host
	uart uart_i (
		.clk (clk),
		.rst (rst),
		.rx (rx),
		.tx (tx),
		.link (link.uart)
	);

	// command parser and dump sequencer
	debug_unit debug_unit_i (
		.clk (clk),
		.rst (rst),
		.link (link.debug),
		.core (core_dbg.debug)
	);

	// single-cycle core, same clock, run_en replaces clock gating
	mips_core mips_core_i (
		.clk (clk),
		.rst (rst),
		.dbg (core_dbg.core)
	);

	// low pc bits on the board leds
	assign led = core_dbg.pc[7:0];

endmodule

`default_nettype wire

// ==== rtl/uart.sv ====
`default_nettype none

module uart (
	input logic clk,
	input logic rst,
	input logic rx,
	output logic tx,
	uart_link_if.uart link
);

	////////////////////////////////////////////////////////////////////////////
	// receiver
	////////////////////////////////////////////////////////////////////////////

	// two-flop sync on the async line
	logic rx_meta;
	logic rx_s;
	logic [1:0] rx_state;
	logic [mips_debug_pkg::baud_cnt_w-1:0] rx_cnt;
	logic [2:0] rx_bit;
	logic [7:0] rx_shift;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_s <= rx_meta;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_state <= mips_debug_pkg::ser_idle;
			rx_cnt <= '0;
			rx_bit <= '0;
			link.rx_done <= 1'b0;
		end else begin
			link.rx_done <= 1'b0;
			case (rx_state)
				mips_debug_pkg::ser_idle: begin
					// falling edge starts a frame
					if (!rx_s) begin
						rx_cnt <= '0;
						rx_state <= mips_debug_pkg::ser_start;
					end
				end
				mips_debug_pkg::ser_start: begin
					// middle of start bit, reject glitches
					if (rx_cnt == mips_debug_pkg::half_last) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						rx_state <= rx_s ? mips_debug_pkg::ser_idle : mips_debug_pkg::ser_data;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				mips_debug_pkg::ser_data: begin
					if (rx_cnt == mips_debug_pkg::bit_last) begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 1'b1;
						if (rx_bit == 3'd7)
							rx_state <= mips_debug_pkg::ser_stop;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				default: begin
					// middle of stop bit, byte is done
					if (rx_cnt == mips_debug_pkg::bit_last) begin
						link.rx_done <= 1'b1;
						rx_state <= mips_debug_pkg::ser_idle;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge clk) begin
		if (rx_state == mips_debug_pkg::ser_data && rx_cnt == mips_debug_pkg::bit_last)
			rx_shift <= {rx_s, rx_shift[7:1]};
		if (rx_state == mips_debug_pkg::ser_stop && rx_cnt == mips_debug_pkg::bit_last)
			link.rx_data <= rx_shift;
	end

	////////////////////////////////////////////////////////////////////////////
	// transmitter
	////////////////////////////////////////////////////////////////////////////

	logic [1:0] tx_state;
	logic [mips_debug_pkg::baud_cnt_w-1:0] tx_cnt;
	logic [2:0] tx_bit;
	logic [7:0] tx_shift;

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_state <= mips_debug_pkg::ser_idle;
			tx_cnt <= '0;
			tx_bit <= '0;
			tx <= 1'b1;
			link.tx_done <= 1'b0;
		end else begin
			link.tx_done <= 1'b0;
			case (tx_state)
				mips_debug_pkg::ser_idle: begin
					if (link.tx_start) begin
						tx <= 1'b0;
						tx_cnt <= '0;
						tx_state <= mips_debug_pkg::ser_start;
					end
				end
				mips_debug_pkg::ser_start: begin
					if (tx_cnt == mips_debug_pkg::bit_last) begin
						tx_cnt <= '0;
						tx_bit <= '0;
						tx <= tx_shift[0];
						tx_state <= mips_debug_pkg::ser_data;
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				mips_debug_pkg::ser_data: begin
					if (tx_cnt == mips_debug_pkg::bit_last) begin
						tx_cnt <= '0;
						tx_bit <= tx_bit + 1'b1;
						// next data bit, or stop level after bit 7
						if (tx_bit == 3'd7) begin
							tx <= 1'b1;
							tx_state <= mips_debug_pkg::ser_stop;
						end else begin
							tx <= tx_shift[1];
						end
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
				default: begin
					if (tx_cnt == mips_debug_pkg::bit_last) begin
						link.tx_done <= 1'b1;
						tx_state <= mips_debug_pkg::ser_idle;
					end else begin
						tx_cnt <= tx_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// byte latched on start, shifted right per bit
	always_ff @(posedge clk) begin
		if (tx_state == mips_debug_pkg::ser_idle && link.tx_start)
			tx_shift <= link.tx_data;
		else if (tx_state == mips_debug_pkg::ser_data && tx_cnt == mips_debug_pkg::bit_last)
			tx_shift <= {1'b0, tx_shift[7:1]};
	end

endmodule

`default_nettype wire

// ==== rtl/uart_link_if.sv ====
`default_nettype none

// byte strobes between debug unit and uart
interface uart_link_if;
	logic [7:0] rx_data;
	logic rx_done;
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_done;

	modport uart (output rx_data, rx_done, tx_done, input tx_data, tx_start);
	modport debug (input rx_data, rx_done, tx_done, output tx_data, tx_start);
endinterface

// program load, run control and state readback
interface core_dbg_if;
	logic imem_we;
	logic [mips_debug_pkg::imem_addr_w-1:0] imem_addr;
	logic [31:0] imem_data;
	logic run_en;
	logic clear;
	logic halted;
	logic [31:0] pc;
	mips_debug_pkg::reg_file_t regs;

	modport debug (output imem_we, imem_addr, imem_data, run_en, clear,
		input halted, pc, regs);
	modport core (input imem_we, imem_addr, imem_data, run_en, clear,
		output halted, pc, regs);
endinterface

`default_nettype wire

// ==== verification/mips_debug_chk.sv ====
`default_nettype none

// protocol checks on the debug unit's links, bound into debug_unit
module mips_debug_chk (
	input logic clk,
	input logic rst,
	input logic run_en,
	input logic halted,
	input logic imem_we,
	input logic tx_start,
	input logic tx_done,
	input logic [2:0] state
);

	// byte handed to the uart, its tx_done not seen yet
	logic in_flight;

	always_ff @(posedge clk) begin
		if (rst)
			in_flight <= 1'b0;
		else if (tx_start)
			in_flight <= 1'b1;
		else if (tx_done)
			in_flight <= 1'b0;
	end

	// a halted core must be cleared by a load before it runs again
	run_en_vs_halt: assert property (@(posedge clk) disable iff (rst)
		$rose(run_en) |-> !halted)
		else $error("run_en rose while the core was halted");

	// no program writes while the core executes
	no_load_in_run: assert property (@(posedge clk) disable iff (rst)
		(state == mips_debug_pkg::dbg_run) |-> !imem_we)
		else $error("imem_we high while the debug unit was in the run state");

	// start only from an idle transmitter
	start_when_idle: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> !in_flight)
		else $error("tx_start issued while a byte was still being sent");

endmodule

`default_nettype wire

// ==== verification/mips_debug_tb.sv ====
`default_nettype none

module mips_debug_tb;

	// one table row: optional load, optional junk byte, then run or step
	typedef struct {
		logic load;
		logic junk;
		logic [7:0] cmd;
		int nwords;
		logic [0:7][31:0] prog;
		logic [0:7][31:0] regs;
		logic [31:0] pc;
	} row_t;

	logic clk;
	logic rst;
	logic rx;
	logic tx;
	logic [7:0] led;
	row_t rows [8];
	int errors;
	int checks;

	mips_debug_top mips_debug_top_i (
		.clk (clk),
		.rst (rst),
		.rx (rx),
		.tx (tx),
		.led (led)
	);

	bind debug_unit mips_debug_chk chk_i (
		.clk (clk),
		.rst (rst),
		.run_en (core.run_en),
		.halted (core.halted),
		.imem_we (core.imem_we),
		.tx_start (link.tx_start),
		.tx_done (link.tx_done),
		.state (state)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoders, straight from the field layout
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] encode_r(logic [5:0] funct, int rd, int rs, int rt);
		return {mips_debug_pkg::op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic logic [31:0] encode_i(logic [5:0] op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// serial host
	////////////////////////////////////////////////////////////////////////////

	// random idle gap, then start, 8 data bits lsb first, stop
	task automatic send_byte(input logic [7:0] b);
		int gap;
		int i;
		logic [9:0] frame;
		gap = $urandom % 6;
		frame = {1'b1, b, 1'b0};
		repeat (gap) @(posedge clk);
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frame[i];
			repeat (mips_debug_pkg::clks_per_bit - 1) @(posedge clk);
		end
	endtask

	task automatic send_word(input logic [31:0] w);
		int i;
		for (i = 0; i < 4; i++)
			send_byte(w[8 * i +: 8]);
	endtask

	// sampled on falling edges, mid bit
	task automatic recv_byte(output logic [7:0] b, output logic ok);
		int n;
		int i;
		ok = 1'b0;
		b = '0;
		n = 0;
		@(negedge clk);
		while (tx !== 1'b0 && n < 2000) begin
			@(negedge clk);
			n++;
		end
		assert (tx === 1'b0) else begin
			errors++;
			$display("timeout: no start bit on tx within %0d cycles", n);
		end
		if (tx !== 1'b0)
			return;
		repeat (mips_debug_pkg::clks_per_bit / 2) @(negedge clk);
		assert (tx === 1'b0) else begin
			errors++;
			$display("start bit on tx did not last to its middle at %0t", $time);
		end
		for (i = 0; i < 8; i++) begin
			repeat (mips_debug_pkg::clks_per_bit) @(negedge clk);
			b[i] = tx;
		end
		repeat (mips_debug_pkg::clks_per_bit) @(negedge clk);
		assert (tx === 1'b1) else begin
			errors++;
			$display("stop bit on tx was low at %0t", $time);
		end
		ok = 1'b1;
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// 36 bytes, regs 0..7 then pc, lsb first
	task automatic recv_dump(input int r);
		logic [7:0] b;
		logic ok;
		logic [0:8][31:0] got;
		int k;
		for (k = 0; k < mips_debug_pkg::dump_bytes; k++) begin
			recv_byte(b, ok);
			if (!ok)
				return;
			got[k / 4][8 * (k % 4) +: 8] = b;
		end
		for (k = 0; k < mips_debug_pkg::num_regs; k++)
			check_word($sformatf("r%0d", k), got[k], rows[r].regs[k]);
		check_word("pc", got[8], rows[r].pc);
		@(negedge clk);
		check_word("led", {24'd0, led}, {24'd0, rows[r].pc[7:0]});
	endtask

	// tx idle high and led steady for a number of cycles
	task automatic expect_quiet(input int cycles, input logic [7:0] led_exp);
		int n;
		logic bad;
		bad = 1'b0;
		checks++;
		for (n = 0; n < cycles && !bad; n++) begin
			@(negedge clk);
			assert (tx === 1'b1) else begin
				errors++;
				bad = 1'b1;
				$display("Mismatch at %0t: tx got %b expected 1", $time, tx);
			end
			assert (led === led_exp) else begin
				errors++;
				bad = 1'b1;
				$display("Mismatch at %0t: led got %h expected %h", $time, led, led_exp);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus table, expected values worked out by hand
	////////////////////////////////////////////////////////////////////////////

	task automatic fill_table();
		// add/sub/addi straight line
		rows[0].load = 1'b1;
		rows[0].junk = 1'b0;
		rows[0].cmd = mips_debug_pkg::cmd_run;
		rows[0].nwords = 7;
		rows[0].prog = {encode_i(mips_debug_pkg::op_addi, 0, 1, 16'd5),
			encode_i(mips_debug_pkg::op_addi, 0, 2, 16'd7),
			encode_r(mips_debug_pkg::funct_add, 3, 1, 2),
			encode_r(mips_debug_pkg::funct_sub, 4, 2, 1),
			encode_i(mips_debug_pkg::op_addi, 0, 5, 16'hfffd),
			encode_r(mips_debug_pkg::funct_sub, 6, 1, 2),
			{mips_debug_pkg::op_halt, 26'd0}, 32'd0};
		rows[0].regs = {32'd0, 32'd5, 32'd7, 32'd12, 32'd2, 32'hffff_fffd, 32'hffff_fffe, 32'd0};
		rows[0].pc = 32'd6;
		// countdown from 3, r7 counts passes, regs 2..6 carry over
		rows[1] = rows[0];
		rows[1].prog = {encode_i(mips_debug_pkg::op_addi, 0, 1, 16'd3),
			encode_i(mips_debug_pkg::op_addi, 0, 7, 16'd0),
			encode_i(mips_debug_pkg::op_addi, 7, 7, 16'd1),
			encode_i(mips_debug_pkg::op_addi, 1, 1, 16'hffff),
			encode_i(mips_debug_pkg::op_beq, 1, 0, 16'd1),
			encode_i(mips_debug_pkg::op_beq, 0, 0, 16'hfffc),
			{mips_debug_pkg::op_halt, 26'd0}, 32'd0};
		rows[1].regs = {32'd0, 32'd0, 32'd7, 32'd12, 32'd2, 32'hffff_fffd, 32'hffff_fffe, 32'd3};
		rows[1].pc = 32'd6;
		// stepping, taken beq skips words 2 and 3
		rows[2] = rows[1];
		rows[2].cmd = mips_debug_pkg::cmd_step;
		rows[2].nwords = 6;
		rows[2].prog = {encode_i(mips_debug_pkg::op_addi, 0, 2, 16'd9),
			encode_i(mips_debug_pkg::op_beq, 2, 2, 16'd2),
			encode_i(mips_debug_pkg::op_addi, 0, 3, 16'd100),
			encode_i(mips_debug_pkg::op_addi, 0, 3, 16'd101),
			encode_r(mips_debug_pkg::funct_add, 4, 2, 2),
			{mips_debug_pkg::op_halt, 26'd0}, 32'd0, 32'd0};
		rows[2].regs[2] = 32'd9;
		rows[2].pc = 32'd1;
		rows[3] = rows[2];
		rows[3].load = 1'b0;
		rows[3].pc = 32'd4;
		rows[4] = rows[3];
		rows[4].regs[4] = 32'd18;
		rows[4].pc = 32'd5;
		// step onto halt, pc stays put
		rows[5] = rows[4];
		// reload after halt, writes to r0 dropped
		rows[6] = rows[5];
		rows[6].load = 1'b1;
		rows[6].cmd = mips_debug_pkg::cmd_run;
		rows[6].nwords = 4;
		rows[6].prog = {encode_i(mips_debug_pkg::op_addi, 0, 0, 16'd55),
			encode_r(mips_debug_pkg::funct_add, 0, 2, 2),
			encode_i(mips_debug_pkg::op_addi, 0, 1, 16'd1),
			{mips_debug_pkg::op_halt, 26'd0}, 32'd0, 32'd0, 32'd0, 32'd0};
		rows[6].regs[1] = 32'd1;
		rows[6].pc = 32'd3;
		// unknown byte first, then run on a halted core dumps as is
		rows[7] = rows[6];
		rows[7].load = 1'b0;
		rows[7].junk = 1'b1;
	endtask

	task automatic apply_row(input int r);
		int w;
		if (rows[r].load) begin
			send_byte(mips_debug_pkg::cmd_load);
			send_byte(8'(rows[r].nwords));
			for (w = 0; w < rows[r].nwords; w++)
				send_word(rows[r].prog[w]);
		end
		if (rows[r].junk) begin
			send_byte(8'h5a);
			expect_quiet(mips_debug_pkg::dump_bytes * 10 * mips_debug_pkg::clks_per_bit + 200,
				rows[r].pc[7:0]);
		end
		send_byte(rows[r].cmd);
		recv_dump(r);
	endtask

	initial begin
		int r;
		void'($urandom(95));
		rst = 1'b1;
		rx = 1'b1;
		errors = 0;
		checks = 0;
		fill_table();
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		// idle line and zero pc right after reset
		expect_quiet(100, 8'd0);
		for (r = 0; r < 8; r++)
			apply_row(r);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
